/* Makefile */
# Verilator build and run of the modular squarer testbench
.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module modular_square_tb \
		-f src.f --Mdir obj_dir -o modular_square_tb
	./obj_dir/modular_square_tb

clean:
	rm -rf obj_dir

/* hdl/grid_register.sv */
// grid register stage
module grid_register (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 capture,
   input  modsq_pkg::grid_vec_t col_words,
   output modsq_pkg::grid_vec_t grid,
   output logic                 grid_ready
);
   import modsq_pkg::*;

   cycle_e stage;  // CYCLE_1 while the held columns wait for reduction

   always_ff @(posedge clk) begin
      if (capture) begin
         grid <= col_words;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         stage <= IDLE;
      end else if (capture) begin
         stage <= CYCLE_1;
      end else begin
         stage <= IDLE;
      end
   end

   assign grid_ready = (stage == CYCLE_1);

endmodule

/* hdl/lut_reduce.sv */
// table reduction and accumulation
module lut_reduce #(
   parameter logic [modsq_pkg::MOD_LEN-1:0] MODULUS = 64'h7fff_ffff_ffff_ffc5
) (
   input  logic                 clk,
   input  logic                 reset,
   input  modsq_pkg::grid_vec_t grid,
   input  logic                 grid_ready,
   output modsq_pkg::sq_vec_t   sq_out,
   output logic                 valid
);
   import modsq_pkg::*;

   localparam int UPPER_COLS   = GRID_SIZE - NONRED_ELEMENTS;  // columns 4..11
   localparam int LUT_ADDR_LEN = LOOK_UP_WIDTH + 1;
   localparam int LUT_DEPTH    = 2 ** LUT_ADDR_LEN;

   typedef lut_entry_t [LUT_DEPTH-1:0] lut_table_t;

   // rows past depth stay zero, the low slice only uses the lower half
   function automatic lut_table_t build_table(input int col, input int shift, input int depth);
      lut_table_t tbl;
      tbl = '0;
      for (int a = 0; a < depth; a++) begin
         tbl[a] = reduction_entry(MODULUS, col, shift, LUT_ADDR_LEN'(a));
      end
      return tbl;
   endfunction

   lut_entry_t lo_data [UPPER_COLS];
   lut_entry_t hi_data [UPPER_COLS];
   col_sum_t   acc [NUM_ELEMENTS];
   sq_vec_t    result;

   // one table pair per upper column
   for (genvar u = 0; u < UPPER_COLS; u++) begin : g_lut
      localparam int         COL      = NONRED_ELEMENTS + u;
      localparam lut_table_t LO_TABLE = build_table(COL, 0, 2 ** LOOK_UP_WIDTH);
      localparam lut_table_t HI_TABLE = build_table(COL, LOOK_UP_WIDTH, LUT_DEPTH);

      assign lo_data[u] = LO_TABLE[{1'b0, grid.cols[COL][LOOK_UP_WIDTH-1:0]}];  // bits 7:0
      assign hi_data[u] = HI_TABLE[grid.cols[COL][BIT_LEN-1:LOOK_UP_WIDTH]];    // bits 16:8
   end

   // lower columns plus 16 table words each, well under 2^21
   always_comb begin
      for (int k = 0; k < NONRED_ELEMENTS; k++) begin
         acc[k] = col_sum_t'(grid.cols[k]);
         for (int u = 0; u < UPPER_COLS; u++) begin
            acc[k] = acc[k] + col_sum_t'(lo_data[u][k]) + col_sum_t'(hi_data[u][k]);
         end
      end
      for (int k = NONRED_ELEMENTS; k < NUM_ELEMENTS; k++) begin
         acc[k] = '0;  // redundant words only collect spill
      end
      result.words[0] = carry_reduce(acc[0], '0);
      for (int k = 1; k < NUM_ELEMENTS; k++) begin
         result.words[k] = carry_reduce(acc[k], acc[k-1]);
      end
   end

   always_ff @(posedge clk) begin
      if (grid_ready) begin
         sq_out <= result;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= 1'b0;
      end else begin
         valid <= grid_ready;  // marks the result registered at this edge
      end
   end

endmodule

/* hdl/modsq_pkg.sv */
// modular squarer definitions
package modsq_pkg;

   localparam int WORD_LEN        = 16;  // grid spacing of the words
   localparam int BIT_LEN         = 17;  // stored word width, one redundant bit
   localparam int NONRED_ELEMENTS = 4;
   localparam int NUM_ELEMENTS    = 6;
   localparam int GRID_SIZE       = 2 * NUM_ELEMENTS;
   localparam int LOOK_UP_WIDTH   = 8;   // low slice, the high slice is one bit wider
   localparam int COL_BIT_LEN     = 24;  // raw column sum
   localparam int MOD_LEN         = NONRED_ELEMENTS * WORD_LEN;

   typedef logic [BIT_LEN-1:0]     sq_word_t;
   typedef logic [COL_BIT_LEN-1:0] col_sum_t;

   // one table row, the reduced value as 16 bit words
   typedef logic [NONRED_ELEMENTS-1:0][WORD_LEN-1:0] lut_entry_t;

   typedef struct packed {
      sq_word_t [NUM_ELEMENTS-1:0] words;  // word k weighs 2^(16k)
   } sq_vec_t;

   typedef struct packed {
      sq_word_t [GRID_SIZE-1:0] cols;
   } grid_vec_t;

   typedef enum logic [1:0] {
      IDLE,
      CYCLE_0,   // grid stage
      CYCLE_1    // reduce stage
   } cycle_e;

   // low 16 bits of a column plus the spill of the column below
   function automatic sq_word_t carry_reduce(input col_sum_t col, input col_sum_t below);
      return sq_word_t'(col[WORD_LEN-1:0]) + sq_word_t'(below[COL_BIT_LEN-1:WORD_LEN]);
   endfunction

   // value * 2^(16*col + shift) mod modulus
   // modulus stays below 2^63 so a doubled residue fits in 64 bits
   function automatic lut_entry_t reduction_entry(input logic [MOD_LEN-1:0]  modulus,
                                                  input int                   col,
                                                  input int                   shift,
                                                  input logic [LOOK_UP_WIDTH:0] value);
      logic [MOD_LEN-1:0] weight;
      logic [MOD_LEN-1:0] acc;
      weight = 1;
      for (int i = 0; i < col * WORD_LEN + shift; i++) begin
         weight = weight << 1;
         if (weight >= modulus) begin
            weight = weight - modulus;
         end
      end
      // double and add over the slice bits, msb first
      acc = '0;
      for (int b = LOOK_UP_WIDTH; b >= 0; b--) begin
         acc = acc << 1;
         if (acc >= modulus) begin
            acc = acc - modulus;
         end
         if (value[b]) begin
            acc = acc + weight;
            if (acc >= modulus) begin
               acc = acc - modulus;
            end
         end
      end
      return lut_entry_t'(acc);
   endfunction

endpackage

/* hdl/modular_square.sv */
// repeated modular squarer
module modular_square #(
   parameter logic [modsq_pkg::MOD_LEN-1:0] MODULUS = 64'h7fff_ffff_ffff_ffc5
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               start,
   input  modsq_pkg::sq_vec_t sq_in,
   output modsq_pkg::sq_vec_t sq_out,
   output logic               valid
);
   import modsq_pkg::*;

   cycle_e    state;
   cycle_e    state_next;
   logic      accept;      // start seen while idle
   logic      first_pass;  // operand comes from the input register
   logic      capture;
   sq_vec_t   sq_in_reg;
   sq_vec_t   operand;
   grid_vec_t col_words;
   grid_vec_t grid;
   logic      grid_ready;

   assign accept  = start && (state == IDLE);
   assign capture = (state == CYCLE_0);

   // once started the sequencer runs until reset
   always_comb begin
      case (state)
         IDLE:    state_next = accept ? CYCLE_0 : IDLE;
         CYCLE_0: state_next = CYCLE_1;
         CYCLE_1: state_next = CYCLE_0;
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= IDLE;
         first_pass <= 1'b0;
      end else begin
         state      <= state_next;
         first_pass <= accept;  // high for the first grid stage only
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         sq_in_reg <= sq_in;
      end
   end

   // loopback after the first pass
   assign operand = first_pass ? sq_in_reg : sq_out;

   square_grid u_square_grid (
      .operand   (operand),
      .col_words (col_words)
   );

   grid_register u_grid_register (
      .clk        (clk),
      .reset      (reset),
      .capture    (capture),
      .col_words  (col_words),
      .grid       (grid),
      .grid_ready (grid_ready)
   );

   lut_reduce #(
      .MODULUS (MODULUS)
   ) u_lut_reduce (
      .clk        (clk),
      .reset      (reset),
      .grid       (grid),
      .grid_ready (grid_ready),
      .sq_out     (sq_out),
      .valid      (valid)
   );

endmodule

/* hdl/square_grid.sv */
// squaring grid
module square_grid (
   input  modsq_pkg::sq_vec_t   operand,
   output modsq_pkg::grid_vec_t col_words
);
   import modsq_pkg::*;

   localparam int PROD_LEN = 2 * BIT_LEN;  // 34 bit partial product

   // at most three products land on a column, sums stay below 2^21
   col_sum_t col_sum [GRID_SIZE];

   // each pair once, off-diagonal terms doubled
   always_comb begin
      logic [PROD_LEN-1:0] prod;
      logic [PROD_LEN:0]   term;
      for (int c = 0; c < GRID_SIZE; c++) begin
         col_sum[c] = '0;
      end
      for (int i = 0; i < NUM_ELEMENTS; i++) begin
         for (int j = i; j < NUM_ELEMENTS; j++) begin
            prod = PROD_LEN'(operand.words[i]) * PROD_LEN'(operand.words[j]);
            if (i == j) begin
               term = {1'b0, prod};
            end else begin
               term = {prod, 1'b0};  // a*b + b*a
            end
            // low half on column i+j, high half one column up
            col_sum[i+j]   = col_sum[i+j] + col_sum_t'(term[WORD_LEN-1:0]);
            col_sum[i+j+1] = col_sum[i+j+1] + col_sum_t'(term[PROD_LEN:WORD_LEN]);
         end
      end
   end

   // one carry step between neighbors brings every column back to 17 bits
   always_comb begin
      col_words.cols[0] = carry_reduce(col_sum[0], '0);
      for (int c = 1; c < GRID_SIZE; c++) begin
         col_words.cols[c] = carry_reduce(col_sum[c], col_sum[c-1]);
      end
   end

   // top column has no room for a spill, it is zero while the top word is zero

endmodule

/* src.f */
hdl/modsq_pkg.sv
hdl/square_grid.sv
hdl/grid_register.sv
hdl/lut_reduce.sv
hdl/modular_square.sv
+incdir+testbench
testbench/modular_square_tb.sv

/* testbench/modsq_model.svh */
// modular squaring reference model
`ifndef MODSQ_MODEL_SVH
`define MODSQ_MODEL_SVH

// a * b mod m, full 128 bit product
function automatic logic [63:0] mul_mod(input logic [63:0] a, input logic [63:0] b,
                                        input logic [63:0] m);
   logic [127:0] prod;
   prod = {64'd0, a} * {64'd0, b};
   return 64'(prod % {64'd0, m});
endfunction

// x^(2^n) mod m, n squarings in a row
function automatic logic [63:0] square_times(input logic [63:0] x, input int n,
                                             input logic [63:0] m);
   logic [63:0] r;
   r = x % m;
   for (int i = 0; i < n; i++) begin
      r = mul_mod(r, r, m);
   end
   return r;
endfunction

// value of a redundant vector, word k weighs 2^(16k)
function automatic logic [63:0] eval_redundant(input modsq_pkg::sq_vec_t v,
                                               input logic [63:0] m);
   logic [127:0] sum;
   sum = '0;
   for (int k = 0; k < 6; k++) begin
      sum = sum + ({111'd0, v.words[k]} << (16 * k));
   end
   return 64'(sum % {64'd0, m});
endfunction

// plain 64 bit value onto the four low words
function automatic modsq_pkg::sq_vec_t to_operand(input logic [63:0] x);
   modsq_pkg::sq_vec_t v;
   v = '0;
   for (int k = 0; k < 4; k++) begin
      v.words[k] = {1'b0, x[16*k +: 16]};
   end
   return v;
endfunction

`endif

/* testbench/modular_square_tb.sv */
// modular squarer testbench
module modular_square_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import modsq_pkg::*;

   localparam logic [63:0] MODULUS   = 64'h5a3c_9e1d_74b2_f0c7;  // odd, below 2^63
   localparam int          MAX_WAIT  = 20;

   logic    clk = 1'b0;
   logic    reset;
   logic    start;
   sq_vec_t sq_in;
   sq_vec_t sq_out;
   logic    valid;
   int      cycle_count = 0;  // rising edges since time zero

   `include "modsq_model.svh"

   modular_square #(
      .MODULUS (MODULUS)
   ) dut (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .valid  (valid)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [63:0] random_operand();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r % MODULUS;
   endfunction

   task automatic apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      start <= 1'b0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
   endtask

   // one cycle start pulse, returns the edge count of the driving edge
   task automatic start_run(input logic [63:0] op, output int start_cnt);
      @(posedge clk);
      start <= 1'b1;
      sq_in <= to_operand(op);
      @(negedge clk);
      start_cnt = cycle_count;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic wait_valid(input string name);
      logic seen;
      seen = 1'b0;
      for (int i = 0; i < MAX_WAIT && !seen; i++) begin
         @(negedge clk);
         seen = valid;
      end
      if (!seen) begin
         $display("valid never came within %0d cycles during %s", MAX_WAIT, name);
         $display("TEST FAILED");
         $fatal(1, "timeout waiting for valid");
      end
   endtask

   task automatic check_idle(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         check_value($sformatf("idle after reset, cycle %0d", i), 64'd0, 64'(valid));
      end
   endtask

   // restart_at > 0 pulses start again right after that result
   task automatic run_squares(input string name, input logic [63:0] op, input int iters,
                              input int restart_at);
      int          start_cnt;
      int          last_cnt;
      int          dummy_cnt;
      logic [63:0] expected;
      logic [63:0] actual;
      start_run(op, start_cnt);
      last_cnt = start_cnt;
      for (int n = 1; n <= iters; n++) begin
         wait_valid(name);
         expected = square_times(op, n, MODULUS);
         actual   = eval_redundant(sq_out, MODULUS);
         check_value($sformatf("%s result %0d", name, n), expected, actual);
         if (n == 1) begin
            check_value($sformatf("%s latency", name), 64'd3, 64'(cycle_count - start_cnt));
         end else begin
            check_value($sformatf("%s interval %0d", name, n), 64'd2,
                        64'(cycle_count - last_cnt));
         end
         last_cnt = cycle_count;
         if (n == restart_at) begin
            start_run(random_operand(), dummy_cnt);  // must be ignored while running
         end
      end
   endtask

   initial begin
      int unsigned seed_draw;
      logic [63:0] op;
      reset = 1'b1;
      start = 1'b0;
      sq_in = '0;
      seed_draw = $urandom(32'h353);

      apply_reset();
      check_idle(10);
      run_squares("single square", random_operand(), 1, 0);

      // same operand twice, the second run gets a stray start
      op = random_operand();
      apply_reset();
      run_squares("repeated squaring", op, 16, 0);
      apply_reset();
      run_squares("ignored restart", op, 16, 5);

      apply_reset();
      run_squares("zero operand", 64'd0, 4, 0);
      apply_reset();
      run_squares("one operand", 64'd1, 4, 0);
      apply_reset();
      run_squares("modulus minus one", MODULUS - 64'd1, 4, 0);

      for (int r = 0; r < 20; r++) begin
         apply_reset();
         run_squares($sformatf("random run %0d", r), random_operand(), 8, 0);
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule
